// File: verilog/ex1Pkg.sv
package ex1Pkg;

	// basic data types
	typedef logic [63:0] word_t;
	typedef logic [47:0] vaddr_t;
	typedef logic [5:0] gprId_t;

	// discard register, writes here are dropped
	localparam gprId_t GrZero = 6'h3F;

	// condition field of an op
	typedef enum logic [1:0] {
		CcAlways = 2'b00,
		CcNever = 2'b01,
		CcIfTrue = 2'b10,
		CcIfFalse = 2'b11
	} condCode_e;

	// major opcodes
	typedef enum logic [5:0] {
		Nop = 6'h00,
		InvOp,
		LeaMr,
		MovRm,
		MovMr,
		Alu3,
		MovIr,
		Bra,
		BraNb,
		Bsr,
		Jmp,
		Jsr,
		OpIxs,
		OpIxt
	} uCmd_e;

	// sub-ops under OpIxs
	typedef enum logic [5:0] {
		IxsNop = 6'h00,
		IxsMovt,
		IxsMovnt,
		IxsTrapb
	} ixsOp_e;

	// sub-ops under OpIxt
	typedef enum logic [5:0] {
		IxtNop = 6'h00,
		IxtBreak,
		IxtClrt,
		IxtSett,
		IxtClrs,
		IxtSets,
		IxtNott,
		IxtNots,
		IxtRte,
		IxtTrapa,
		IxtSyse
	} ixtOp_e;

	// memory ops, low two bits are the access size
	typedef enum logic [4:0] {
		MemReady = 5'b00000,
		MemLdB = 5'b01000,
		MemLdW = 5'b01001,
		MemLdD = 5'b01010,
		MemLdQ = 5'b01011,
		MemStB = 5'b10000,
		MemStW = 5'b10001,
		MemStD = 5'b10010,
		MemStQ = 5'b10011,
		MemTrap = 5'b11111
	} memOpm_e;

	// writeback value source
	typedef enum logic [2:0] {
		OutNone,
		OutMemAddr,
		OutRtVal,
		OutSh8,
		OutSh16,
		OutSh32,
		OutMovt,
		OutMovnt
	} outSel_e;

	// branch target source
	typedef enum logic [1:0] {
		BraPc,
		BraRel,
		BraReg
	} braSel_e;

	// SR flag op
	typedef enum logic [2:0] {
		SrKeep,
		SrClrt,
		SrSett,
		SrClrs,
		SrSets,
		SrNott,
		SrNots
	} srOp_e;

	typedef enum logic [1:0] {
		TrapNone,
		TrapRte,
		TrapTrapa,
		TrapSyse
	} trapSel_e;

	// decoded micro-op from the front end
	typedef struct packed {
		logic valid;
		condCode_e cond;
		uCmd_e cmd;
		logic [5:0] ixt;
		gprId_t rs;
		gprId_t rt;
		gprId_t rm;
		word_t rsVal;
		word_t rtVal;
		word_t rmVal;
		word_t pc;
		logic preBraTaken;
	} uop_t;

	// control bundle out of the dispatch decode
	typedef struct packed {
		outSel_e outSel;
		logic doOut;
		logic doMem;
		memOpm_e memOp;
		braSel_e braSel;
		logic doBra;
		srOp_e srOp;
		logic link;
		trapSel_e trapSel;
		logic held;
		logic invalid;
		logic brk;
	} ex1Ctrl_t;

	typedef struct packed {
		logic valid;
		memOpm_e opm;
		vaddr_t addr;
		word_t data;
	} memReq_t;

	typedef struct packed {
		gprId_t rnId;
		word_t rnVal;
		gprId_t heldId;
	} wbOut_t;

	typedef struct packed {
		logic valid;
		logic [15:0] code;
	} trapOut_t;

endpackage

// File: verilog/opDispatch.sv
`timescale 1ns/1ps

module opDispatch (
	input ex1Pkg::uop_t uop,
	input logic srT,
	input logic braFlush,
	output ex1Pkg::ex1Ctrl_t ctrl
);

	logic opEnable;
	ex1Pkg::uCmd_e effCmd;

	// predication against SR.T
	always_comb begin
		case (uop.cond)
			ex1Pkg::CcAlways: opEnable = 1'b1;
			ex1Pkg::CcNever: opEnable = 1'b0;
			ex1Pkg::CcIfTrue: opEnable = srT;
			ex1Pkg::CcIfFalse: opEnable = !srT;
			default: opEnable = 1'b0;
		endcase
		// flush kills every op
		if (braFlush)
			opEnable = 1'b0;
	end

	// disabled bra still has to undo a predicted-taken fetch
	always_comb begin
		if (!uop.valid)
			effCmd = ex1Pkg::Nop;
		else if (opEnable)
			effCmd = uop.cmd;
		else if (uop.cmd == ex1Pkg::Bra && !braFlush)
			effCmd = ex1Pkg::BraNb;
		else
			effCmd = ex1Pkg::Nop;
	end

	always_comb begin
		ctrl = '0;
		case (effCmd)
			ex1Pkg::Nop: begin
			end
			ex1Pkg::InvOp: ctrl.invalid = 1'b1;
			ex1Pkg::LeaMr: begin
				ctrl.outSel = ex1Pkg::OutMemAddr;
				ctrl.doOut = 1'b1;
			end
			ex1Pkg::MovRm: begin
				ctrl.doMem = 1'b1;
				ctrl.memOp = ex1Pkg::MemStB;
			end
			ex1Pkg::MovMr: begin
				ctrl.doMem = 1'b1;
				ctrl.memOp = ex1Pkg::MemLdB;
				ctrl.held = 1'b1;
			end
			// result comes from a later stage
			ex1Pkg::Alu3: ctrl.held = 1'b1;
			ex1Pkg::MovIr: begin
				ctrl.doOut = 1'b1;
				case (uop.ixt[3:0])
					4'h0: ctrl.outSel = ex1Pkg::OutRtVal;
					4'h1: ctrl.outSel = ex1Pkg::OutSh8;
					4'h2: ctrl.outSel = ex1Pkg::OutSh16;
					4'h3: ctrl.outSel = ex1Pkg::OutSh32;
					default: ctrl.invalid = 1'b1;
				endcase
			end
			// static prediction repair
			ex1Pkg::Bra: begin
				ctrl.braSel = ex1Pkg::BraRel;
				ctrl.doBra = !uop.preBraTaken;
			end
			ex1Pkg::BraNb: begin
				ctrl.braSel = ex1Pkg::BraPc;
				ctrl.doBra = uop.preBraTaken;
			end
			ex1Pkg::Bsr: begin
				ctrl.braSel = ex1Pkg::BraRel;
				ctrl.doBra = !uop.preBraTaken;
				ctrl.link = 1'b1;
			end
			ex1Pkg::Jmp: begin
				ctrl.braSel = ex1Pkg::BraReg;
				ctrl.doBra = !uop.preBraTaken;
			end
			ex1Pkg::Jsr: begin
				ctrl.braSel = ex1Pkg::BraReg;
				ctrl.doBra = 1'b1;
				ctrl.link = 1'b1;
			end
			ex1Pkg::OpIxs: begin
				case (ex1Pkg::ixsOp_e'(uop.ixt))
					ex1Pkg::IxsNop: begin
					end
					ex1Pkg::IxsMovt: begin
						ctrl.outSel = ex1Pkg::OutMovt;
						ctrl.doOut = 1'b1;
					end
					ex1Pkg::IxsMovnt: begin
						ctrl.outSel = ex1Pkg::OutMovnt;
						ctrl.doOut = 1'b1;
					end
					ex1Pkg::IxsTrapb: begin
						ctrl.doMem = 1'b1;
						ctrl.memOp = ex1Pkg::MemTrap;
					end
					default: ctrl.invalid = 1'b1;
				endcase
			end
			ex1Pkg::OpIxt: begin
				case (ex1Pkg::ixtOp_e'(uop.ixt))
					ex1Pkg::IxtNop: begin
					end
					ex1Pkg::IxtBreak: ctrl.brk = 1'b1;
					ex1Pkg::IxtClrt: ctrl.srOp = ex1Pkg::SrClrt;
					ex1Pkg::IxtSett: ctrl.srOp = ex1Pkg::SrSett;
					ex1Pkg::IxtClrs: ctrl.srOp = ex1Pkg::SrClrs;
					ex1Pkg::IxtSets: ctrl.srOp = ex1Pkg::SrSets;
					ex1Pkg::IxtNott: ctrl.srOp = ex1Pkg::SrNott;
					ex1Pkg::IxtNots: ctrl.srOp = ex1Pkg::SrNots;
					ex1Pkg::IxtRte: ctrl.trapSel = ex1Pkg::TrapRte;
					ex1Pkg::IxtTrapa: ctrl.trapSel = ex1Pkg::TrapTrapa;
					ex1Pkg::IxtSyse: ctrl.trapSel = ex1Pkg::TrapSyse;
					default: ctrl.invalid = 1'b1;
				endcase
			end
			default: ctrl.invalid = 1'b1;
		endcase
	end

endmodule

// File: verilog/addrGen.sv
`timescale 1ns/1ps

module addrGen (
	input ex1Pkg::uop_t uop,
	output ex1Pkg::vaddr_t memAddr,
	output ex1Pkg::vaddr_t braAddr
);

	ex1Pkg::vaddr_t idxScaled;
	ex1Pkg::vaddr_t braDisp;
	logic [16:0] sumLo;
	logic [16:0] sumMid0;
	logic [16:0] sumMid1;
	logic [15:0] sumHi0;
	logic [15:0] sumHi1;
	logic midCarry;

	// base plus index scaled by access size
	assign idxScaled = uop.rtVal[47:0] << uop.ixt[5:4];
	assign memAddr = uop.rsVal[47:0] + idxScaled;

	// branch displacement in 16-bit units
	assign braDisp = {uop.rtVal[46:0], 1'b0};

	// carry-select slices, both upper sums ready before the low carry
	assign sumLo = {1'b0, uop.pc[15:0]} + {1'b0, braDisp[15:0]};
	assign sumMid0 = {1'b0, uop.pc[31:16]} + {1'b0, braDisp[31:16]};
	assign sumMid1 = {1'b0, uop.pc[31:16]} + {1'b0, braDisp[31:16]} + 17'd1;
	assign sumHi0 = uop.pc[47:32] + braDisp[47:32];
	assign sumHi1 = uop.pc[47:32] + braDisp[47:32] + 16'd1;

	// carry into the top slice
	assign midCarry = sumLo[16] ? sumMid1[16] : sumMid0[16];

	assign braAddr = {
		midCarry ? sumHi1 : sumHi0,
		sumLo[16] ? sumMid1[15:0] : sumMid0[15:0],
		sumLo[15:0]
	};

endmodule

// File: verilog/srUpdate.sv
`timescale 1ns/1ps

module srUpdate (
	input ex1Pkg::ex1Ctrl_t ctrl,
	input ex1Pkg::word_t srIn,
	output ex1Pkg::word_t srNext,
	output ex1Pkg::word_t tValue
);

	logic srT;

	assign srT = srIn[0];

	// bit 0 is T, bit 1 is S
	always_comb begin
		srNext = srIn;
		case (ctrl.srOp)
			ex1Pkg::SrClrt: srNext[0] = 1'b0;
			ex1Pkg::SrSett: srNext[0] = 1'b1;
			ex1Pkg::SrClrs: srNext[1] = 1'b0;
			ex1Pkg::SrSets: srNext[1] = 1'b1;
			ex1Pkg::SrNott: srNext[0] = !srIn[0];
			ex1Pkg::SrNots: srNext[1] = !srIn[1];
			default: srNext = srIn;
		endcase
	end

	// movt / movnt result, zero-extended
	always_comb begin
		tValue = '0;
		if (ctrl.outSel == ex1Pkg::OutMovnt)
			tValue[0] = !srT;
		else
			tValue[0] = srT;
	end

endmodule

// File: verilog/memIssue.sv
`timescale 1ns/1ps

module memIssue #(
	parameter int MemCredits = 4
) (
	input logic clock,
	input logic rstN,
	input ex1Pkg::ex1Ctrl_t ctrl,
	input ex1Pkg::uop_t uop,
	input ex1Pkg::vaddr_t memAddr,
	input logic accept,
	input logic memCredit,
	output logic memStall,
	output ex1Pkg::memReq_t memReq
);

	localparam int CntW = $clog2(MemCredits + 1);

	logic [CntW-1:0] creditCnt;
	logic spend;
	ex1Pkg::memOpm_e opmNext;
	logic reqValidQ;
	ex1Pkg::memOpm_e reqOpmQ;
	ex1Pkg::vaddr_t reqAddrQ;
	ex1Pkg::word_t reqDataQ;

	// no credit left, op waits
	assign memStall = ctrl.doMem && (creditCnt == '0);
	assign spend = accept && ctrl.doMem;

	// size field merged into load/store class
	always_comb begin
		if (ctrl.memOp == ex1Pkg::MemTrap)
			opmNext = ex1Pkg::MemTrap;
		else
			opmNext = ex1Pkg::memOpm_e'({ctrl.memOp[4:2], uop.ixt[5:4]});
	end

	// spend and return in one cycle cancel out
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			creditCnt <= CntW'(MemCredits);
			reqValidQ <= 1'b0;
		end else begin
			reqValidQ <= spend;
			if (spend && !memCredit)
				creditCnt <= creditCnt - 1'b1;
			else if (memCredit && !spend)
				creditCnt <= creditCnt + 1'b1;
		end
	end

	// request payload
	always_ff @(posedge clock) begin
		if (spend) begin
			reqOpmQ <= opmNext;
			reqAddrQ <= memAddr;
			reqDataQ <= uop.rmVal;
		end
	end

	assign memReq = '{valid: reqValidQ, opm: reqOpmQ, addr: reqAddrQ, data: reqDataQ};

	// memory side returns no more credits than were handed out
	creditBound: assert property (@(posedge clock) disable iff (!rstN)
		creditCnt <= CntW'(MemCredits));

	// every issued request had a credit when accepted
	noReqWithoutCredit: assert property (@(posedge clock) disable iff (!rstN)
		reqValidQ |-> $past(creditCnt) != '0);

endmodule

// File: verilog/ex1Writeback.sv
`timescale 1ns/1ps

module ex1Writeback (
	input logic clock,
	input logic rstN,
	input ex1Pkg::uop_t uop,
	input ex1Pkg::ex1Ctrl_t ctrl,
	input ex1Pkg::vaddr_t memAddr,
	input ex1Pkg::vaddr_t braAddr,
	input ex1Pkg::word_t srNext,
	input ex1Pkg::word_t tValue,
	input ex1Pkg::word_t lrIn,
	input ex1Pkg::word_t dlrIn,
	input logic memStall,
	output logic accept,
	output logic exHold,
	output ex1Pkg::wbOut_t wb,
	output logic braValid,
	output ex1Pkg::word_t braTarget,
	output ex1Pkg::word_t srOut,
	output ex1Pkg::word_t lrOut,
	output ex1Pkg::trapOut_t trap
);

	ex1Pkg::word_t resultVal;
	ex1Pkg::word_t braVal;
	logic [15:0] trapCode;
	ex1Pkg::gprId_t rnIdQ;
	ex1Pkg::gprId_t heldIdQ;
	ex1Pkg::word_t rnValQ;
	logic trapValidQ;
	logic [15:0] trapCodeQ;

	// invalid op, break and memory stall all hold the producer
	assign exHold = uop.valid && (ctrl.invalid || ctrl.brk || memStall);
	assign accept = uop.valid && !exHold;

	// result select
	always_comb begin
		case (ctrl.outSel)
			ex1Pkg::OutMemAddr: resultVal = {16'h0000, memAddr};
			ex1Pkg::OutRtVal: resultVal = uop.rtVal;
			ex1Pkg::OutSh8: resultVal = {uop.rsVal[55:0], uop.rtVal[7:0]};
			ex1Pkg::OutSh16: resultVal = {uop.rsVal[47:0], uop.rtVal[15:0]};
			ex1Pkg::OutSh32: resultVal = {uop.rsVal[31:0], uop.rtVal[31:0]};
			ex1Pkg::OutMovt, ex1Pkg::OutMovnt: resultVal = tValue;
			default: resultVal = '0;
		endcase
	end

	// branch target keeps the upper pc bits
	always_comb begin
		case (ctrl.braSel)
			ex1Pkg::BraRel: braVal = {uop.pc[63:48], braAddr};
			ex1Pkg::BraReg: braVal = {uop.pc[63:48], uop.rsVal[47:0]};
			default: braVal = uop.pc;
		endcase
	end

	// 16-bit trap code
	always_comb begin
		case (ctrl.trapSel)
			ex1Pkg::TrapRte: trapCode = 16'hFF00;
			ex1Pkg::TrapTrapa: trapCode = {12'hC08, uop.rm[3:0]};
			ex1Pkg::TrapSyse: trapCode = {4'hE, dlrIn[11:0]};
			default: trapCode = 16'h0000;
		endcase
	end

	// ids and valids go idle unless an op was taken
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			rnIdQ <= ex1Pkg::GrZero;
			heldIdQ <= ex1Pkg::GrZero;
			braValid <= 1'b0;
			trapValidQ <= 1'b0;
		end else begin
			rnIdQ <= (accept && ctrl.doOut) ? uop.rm : ex1Pkg::GrZero;
			heldIdQ <= (accept && ctrl.held) ? uop.rm : ex1Pkg::GrZero;
			braValid <= accept && ctrl.doBra;
			trapValidQ <= accept && (ctrl.trapSel != ex1Pkg::TrapNone);
		end
	end

	// payload registers
	// srNext equals srIn when nothing is taken
	always_ff @(posedge clock) begin
		rnValQ <= resultVal;
		braTarget <= braVal;
		trapCodeQ <= trapCode;
		srOut <= srNext;
		lrOut <= (accept && ctrl.link) ? uop.pc : lrIn;
	end

	assign wb = '{rnId: rnIdQ, rnVal: rnValQ, heldId: heldIdQ};
	assign trap = '{valid: trapValidQ, code: trapCodeQ};

	// held or idle ops never carry a flag op into srOut
	srPassOnHold: assert property (@(posedge clock) disable iff (!rstN)
		!accept |-> ctrl.srOp == ex1Pkg::SrKeep);

endmodule

// File: verilog/ex1Stage.sv
`timescale 1ns/1ps

module ex1Stage #(
	parameter int MemCredits = 4
) (
	input logic clock,
	input logic rstN,
	input ex1Pkg::uop_t uop,
	input ex1Pkg::word_t srIn,
	input ex1Pkg::word_t lrIn,
	input ex1Pkg::word_t dlrIn,
	input logic braFlush,
	input logic memCredit,
	output logic exHold,
	output ex1Pkg::wbOut_t wb,
	output logic braValid,
	output ex1Pkg::word_t braTarget,
	output ex1Pkg::word_t srOut,
	output ex1Pkg::word_t lrOut,
	output ex1Pkg::trapOut_t trap,
	output ex1Pkg::memReq_t memReq
);

	ex1Pkg::ex1Ctrl_t ctrl;
	ex1Pkg::vaddr_t memAddr;
	ex1Pkg::vaddr_t braAddr;
	ex1Pkg::word_t srNext;
	ex1Pkg::word_t tValue;
	logic accept;
	logic memStall;

	// predication uses SR.T
	opDispatch opDispatch_i (
		.uop(uop),
		.srT(srIn[0]),
		.braFlush(braFlush),
		.ctrl(ctrl)
	);

	addrGen addrGen_i (
		.uop(uop),
		.memAddr(memAddr),
		.braAddr(braAddr)
	);

	srUpdate srUpdate_i (
		.ctrl(ctrl),
		.srIn(srIn),
		.srNext(srNext),
		.tValue(tValue)
	);

	// credit flow control toward memory
	memIssue #(
		.MemCredits(MemCredits)
	) memIssue_i (
		.clock(clock),
		.rstN(rstN),
		.ctrl(ctrl),
		.uop(uop),
		.memAddr(memAddr),
		.accept(accept),
		.memCredit(memCredit),
		.memStall(memStall),
		.memReq(memReq)
	);

	ex1Writeback ex1Writeback_i (
		.clock(clock),
		.rstN(rstN),
		.uop(uop),
		.ctrl(ctrl),
		.memAddr(memAddr),
		.braAddr(braAddr),
		.srNext(srNext),
		.tValue(tValue),
		.lrIn(lrIn),
		.dlrIn(dlrIn),
		.memStall(memStall),
		.accept(accept),
		.exHold(exHold),
		.wb(wb),
		.braValid(braValid),
		.braTarget(braTarget),
		.srOut(srOut),
		.lrOut(lrOut),
		.trap(trap)
	);

endmodule

// File: verif/ex1Model.svh
`ifndef EX1_MODEL_SVH
`define EX1_MODEL_SVH

// expected stage outputs for one presented op
typedef struct packed {
	logic hold;
	logic isMem;
	logic isStore;
	ex1Pkg::gprId_t rnId;
	ex1Pkg::word_t rnVal;
	ex1Pkg::gprId_t heldId;
	logic braValid;
	ex1Pkg::word_t braTarget;
	ex1Pkg::word_t srOut;
	ex1Pkg::word_t lrOut;
	logic trapValid;
	logic [15:0] trapCode;
	logic memValid;
	ex1Pkg::memOpm_e memOpm;
	ex1Pkg::vaddr_t memAddr;
	ex1Pkg::word_t memData;
} expOut_t;

// load or store class with the access size
function automatic ex1Pkg::memOpm_e sizedOpm(input logic store, input logic [1:0] size);
	ex1Pkg::memOpm_e opm;
	case (size)
		2'd0: opm = store ? ex1Pkg::MemStB : ex1Pkg::MemLdB;
		2'd1: opm = store ? ex1Pkg::MemStW : ex1Pkg::MemLdW;
		2'd2: opm = store ? ex1Pkg::MemStD : ex1Pkg::MemLdD;
		default: opm = store ? ex1Pkg::MemStQ : ex1Pkg::MemLdQ;
	endcase
	return opm;
endfunction

function automatic expOut_t ex1Expect(
	input ex1Pkg::uop_t u,
	input ex1Pkg::word_t sr,
	input ex1Pkg::word_t lr,
	input ex1Pkg::word_t dlr,
	input logic flush,
	input int credits
);
	expOut_t idle;
	expOut_t e;
	logic enabled;
	logic invalid;
	logic brk;
	ex1Pkg::uCmd_e cmd;
	ex1Pkg::vaddr_t addr;
	ex1Pkg::vaddr_t rel;
	logic [1:0] size;

	// nothing taken, sr and lr pass through
	idle = '0;
	idle.rnId = ex1Pkg::GrZero;
	idle.heldId = ex1Pkg::GrZero;
	idle.srOut = sr;
	idle.lrOut = lr;
	e = idle;
	invalid = 1'b0;
	brk = 1'b0;
	size = u.ixt[5:4];
	// base plus scaled index, 48-bit wrap
	addr = u.rsVal[47:0] + (u.rtVal[47:0] << size);
	// displacement counts halfwords
	rel = u.pc[47:0] + {u.rtVal[46:0], 1'b0};

	case (u.cond)
		ex1Pkg::CcAlways: enabled = 1'b1;
		ex1Pkg::CcNever: enabled = 1'b0;
		ex1Pkg::CcIfTrue: enabled = sr[0];
		default: enabled = !sr[0];
	endcase
	enabled = enabled && !flush;

	// skipped bra still repairs a taken prediction
	if (!u.valid)
		cmd = ex1Pkg::Nop;
	else if (enabled)
		cmd = u.cmd;
	else if (u.cmd == ex1Pkg::Bra && !flush)
		cmd = ex1Pkg::BraNb;
	else
		cmd = ex1Pkg::Nop;

	case (cmd)
		ex1Pkg::Nop: begin
		end
		ex1Pkg::LeaMr: begin
			e.rnId = u.rm;
			e.rnVal = {16'h0000, addr};
		end
		ex1Pkg::MovRm: begin
			e.memValid = 1'b1;
			e.isStore = 1'b1;
			e.memOpm = sizedOpm(1'b1, size);
			e.memAddr = addr;
			e.memData = u.rmVal;
		end
		ex1Pkg::MovMr: begin
			e.memValid = 1'b1;
			e.memOpm = sizedOpm(1'b0, size);
			e.memAddr = addr;
			e.heldId = u.rm;
		end
		// finishes in a later stage
		ex1Pkg::Alu3: e.heldId = u.rm;
		ex1Pkg::MovIr: begin
			e.rnId = u.rm;
			case (u.ixt[3:0])
				4'h0: e.rnVal = u.rtVal;
				4'h1: e.rnVal = {u.rsVal[55:0], u.rtVal[7:0]};
				4'h2: e.rnVal = {u.rsVal[47:0], u.rtVal[15:0]};
				4'h3: e.rnVal = {u.rsVal[31:0], u.rtVal[31:0]};
				default: invalid = 1'b1;
			endcase
		end
		ex1Pkg::Bra: begin
			e.braValid = !u.preBraTaken;
			e.braTarget = {u.pc[63:48], rel};
		end
		ex1Pkg::BraNb: begin
			e.braValid = u.preBraTaken;
			e.braTarget = u.pc;
		end
		ex1Pkg::Bsr: begin
			e.braValid = !u.preBraTaken;
			e.braTarget = {u.pc[63:48], rel};
			e.lrOut = u.pc;
		end
		ex1Pkg::Jmp: begin
			e.braValid = !u.preBraTaken;
			e.braTarget = {u.pc[63:48], u.rsVal[47:0]};
		end
		ex1Pkg::Jsr: begin
			e.braValid = 1'b1;
			e.braTarget = {u.pc[63:48], u.rsVal[47:0]};
			e.lrOut = u.pc;
		end
		ex1Pkg::OpIxs: begin
			case (ex1Pkg::ixsOp_e'(u.ixt))
				ex1Pkg::IxsNop: begin
				end
				ex1Pkg::IxsMovt: begin
					e.rnId = u.rm;
					e.rnVal = {63'd0, sr[0]};
				end
				ex1Pkg::IxsMovnt: begin
					e.rnId = u.rm;
					e.rnVal = {63'd0, !sr[0]};
				end
				ex1Pkg::IxsTrapb: begin
					e.memValid = 1'b1;
					e.memOpm = ex1Pkg::MemTrap;
					e.memAddr = addr;
				end
				default: invalid = 1'b1;
			endcase
		end
		ex1Pkg::OpIxt: begin
			case (ex1Pkg::ixtOp_e'(u.ixt))
				ex1Pkg::IxtNop: begin
				end
				ex1Pkg::IxtBreak: brk = 1'b1;
				ex1Pkg::IxtClrt: e.srOut[0] = 1'b0;
				ex1Pkg::IxtSett: e.srOut[0] = 1'b1;
				ex1Pkg::IxtClrs: e.srOut[1] = 1'b0;
				ex1Pkg::IxtSets: e.srOut[1] = 1'b1;
				ex1Pkg::IxtNott: e.srOut[0] = !sr[0];
				ex1Pkg::IxtNots: e.srOut[1] = !sr[1];
				ex1Pkg::IxtRte: begin
					e.trapValid = 1'b1;
					e.trapCode = 16'hFF00;
				end
				ex1Pkg::IxtTrapa: begin
					e.trapValid = 1'b1;
					e.trapCode = {12'hC08, u.rm[3:0]};
				end
				ex1Pkg::IxtSyse: begin
					e.trapValid = 1'b1;
					e.trapCode = {4'hE, dlr[11:0]};
				end
				default: invalid = 1'b1;
			endcase
		end
		default: invalid = 1'b1;
	endcase

	// held op, every output stays idle
	if (invalid || brk || (e.memValid && credits == 0)) begin
		idle.hold = 1'b1;
		idle.isMem = e.memValid;
		return idle;
	end
	e.isMem = e.memValid;
	return e;
endfunction

`endif

// File: verif/ex1StageTb.sv
`timescale 1ns/1ps

module ex1StageTb;

	localparam int ClkPeriod = 4;
	localparam int NumOps = 1500;
	localparam int Credits = 4;

	logic clock = 1'b0;
	logic rstN;
	ex1Pkg::uop_t uop;
	ex1Pkg::word_t srIn;
	ex1Pkg::word_t lrIn;
	ex1Pkg::word_t dlrIn;
	logic braFlush;
	logic memCredit;
	logic exHold;
	ex1Pkg::wbOut_t wb;
	logic braValid;
	ex1Pkg::word_t braTarget;
	ex1Pkg::word_t srOut;
	ex1Pkg::word_t lrOut;
	ex1Pkg::trapOut_t trap;
	ex1Pkg::memReq_t memReq;

	// own view of the memory credits
	int tbCredits = Credits;
	int acceptCount = 0;
	logic sawStall = 1'b0;
	logic blockCredits = 1'b0;
	logic havePrev = 1'b0;
	int creditDue[$];

	`include "ex1Model.svh"

	expOut_t prevExp;
	expOut_t curExp;

	ex1Stage #(
		.MemCredits(Credits)
	) ex1Stage_i (
		.clock(clock),
		.rstN(rstN),
		.uop(uop),
		.srIn(srIn),
		.lrIn(lrIn),
		.dlrIn(dlrIn),
		.braFlush(braFlush),
		.memCredit(memCredit),
		.exHold(exHold),
		.wb(wb),
		.braValid(braValid),
		.braTarget(braTarget),
		.srOut(srOut),
		.lrOut(lrOut),
		.trap(trap),
		.memReq(memReq)
	);

	always #(ClkPeriod / 2) clock = ~clock;

	task automatic checkValue(input string what, input logic [63:0] got,
		input logic [63:0] want);
		if (got !== want) begin
			$display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("Test FAILED");
			$fatal(1, "mismatch on %s", what);
		end
	endtask

	function automatic ex1Pkg::word_t randomWord();
		return {$urandom(), $urandom()};
	endfunction

	// one op from the kept set, now and then InvOp or BREAK
	function automatic ex1Pkg::uop_t randomOp();
		ex1Pkg::uop_t op;
		int pick;
		int sub;
		op.valid = ($urandom_range(0, 15) != 0);
		if ($urandom_range(0, 1) == 0)
			op.cond = ex1Pkg::CcAlways;
		else
			op.cond = ex1Pkg::condCode_e'(2'($urandom_range(0, 3)));
		op.cmd = ex1Pkg::Nop;
		op.ixt = {2'($urandom_range(0, 3)), 4'h0};
		// rm never hits the discard id
		op.rs = 6'($urandom_range(0, 62));
		op.rt = 6'($urandom_range(0, 62));
		op.rm = 6'($urandom_range(0, 62));
		op.rsVal = randomWord();
		op.rtVal = randomWord();
		op.rmVal = randomWord();
		op.pc = randomWord();
		op.preBraTaken = ($urandom_range(0, 1) == 1);
		pick = $urandom_range(0, 31);
		sub = $urandom_range(0, 10);
		if (pick == 30) begin
			op.cmd = ex1Pkg::InvOp;
		end else if (pick == 31) begin
			op.cmd = ex1Pkg::OpIxt;
			op.ixt = 6'(ex1Pkg::IxtBreak);
		end else begin
			case (pick % 12)
				0: op.cmd = ex1Pkg::LeaMr;
				1: op.cmd = ex1Pkg::MovRm;
				2: op.cmd = ex1Pkg::MovMr;
				3: op.cmd = ex1Pkg::Alu3;
				4: begin
					op.cmd = ex1Pkg::MovIr;
					op.ixt[3:0] = 4'(sub % 4);
				end
				5: op.cmd = ex1Pkg::Bra;
				6: op.cmd = ex1Pkg::Bsr;
				7: op.cmd = ex1Pkg::Jmp;
				8: op.cmd = ex1Pkg::Jsr;
				9: begin
					op.cmd = ex1Pkg::OpIxs;
					op.ixt = 6'(sub % 4);
				end
				10: begin
					op.cmd = ex1Pkg::OpIxt;
					op.ixt = 6'(sub);
					// break only via its own rare pick
					if (op.ixt == 6'(ex1Pkg::IxtBreak))
						op.ixt = 6'(ex1Pkg::IxtNop);
				end
				default: op.cmd = ex1Pkg::Nop;
			endcase
		end
		return op;
	endfunction

	// drive after the edge, then wait until the stage takes it
	task automatic presentOp(input ex1Pkg::uop_t op, input logic flush);
		logic stuck;
		int heldCycles;
		stuck = op.valid && (op.cmd == ex1Pkg::InvOp
			|| (op.cmd == ex1Pkg::OpIxt && op.ixt == 6'(ex1Pkg::IxtBreak)));
		heldCycles = 0;
		@(posedge clock);
		#1;
		uop = op;
		braFlush = flush;
		srIn = randomWord();
		lrIn = randomWord();
		dlrIn = randomWord();
		@(negedge clock);
		// invalid and break get swapped out next cycle
		while (exHold && !stuck) begin
			heldCycles++;
			// stall seen, let memory return credits again
			if (heldCycles == 3)
				blockCredits = 1'b0;
			@(negedge clock);
		end
	endtask

	task automatic compareOutputs(input expOut_t e);
		checkValue("wb.rnId", 64'(wb.rnId), 64'(e.rnId));
		if (e.rnId != ex1Pkg::GrZero)
			checkValue("wb.rnVal", wb.rnVal, e.rnVal);
		checkValue("wb.heldId", 64'(wb.heldId), 64'(e.heldId));
		checkValue("braValid", 64'(braValid), 64'(e.braValid));
		if (e.braValid)
			checkValue("braTarget", braTarget, e.braTarget);
		checkValue("srOut", srOut, e.srOut);
		checkValue("lrOut", lrOut, e.lrOut);
		checkValue("trap.valid", 64'(trap.valid), 64'(e.trapValid));
		if (e.trapValid)
			checkValue("trap.code", 64'(trap.code), 64'(e.trapCode));
		checkValue("memReq.valid", 64'(memReq.valid), 64'(e.memValid));
		if (e.memValid) begin
			checkValue("memReq.opm", 64'(memReq.opm), 64'(e.memOpm));
			checkValue("memReq.addr", 64'(memReq.addr), 64'(e.memAddr));
			if (e.isStore)
				checkValue("memReq.data", memReq.data, e.memData);
		end
	endtask

	// mid-cycle sample, inputs and outputs both settled
	always @(negedge clock) begin
		if (!rstN) begin
			checkValue("wb.rnId in reset", 64'(wb.rnId), 64'(ex1Pkg::GrZero));
			checkValue("wb.heldId in reset", 64'(wb.heldId), 64'(ex1Pkg::GrZero));
			checkValue("braValid in reset", 64'(braValid), 64'd0);
			checkValue("trap.valid in reset", 64'(trap.valid), 64'd0);
			checkValue("memReq.valid in reset", 64'(memReq.valid), 64'd0);
			havePrev = 1'b0;
		end else begin
			// effects of the op taken at the last edge
			if (havePrev)
				compareOutputs(prevExp);
			curExp = ex1Expect(uop, srIn, lrIn, dlrIn, braFlush, tbCredits);
			checkValue("exHold", 64'(exHold), 64'(curExp.hold));
			if (curExp.hold && curExp.isMem)
				sawStall = 1'b1;
			if (uop.valid && !curExp.hold)
				acceptCount++;
			// count as the DUT sees it at the next edge
			if (!curExp.hold && curExp.isMem)
				tbCredits--;
			if (memCredit)
				tbCredits++;
			prevExp = curExp;
			havePrev = 1'b1;
		end
	end

	// memory side, at most one credit back per cycle
	initial begin
		int cycleCount;
		int idx;
		cycleCount = 0;
		memCredit = 1'b0;
		forever begin
			@(negedge clock);
			if (rstN && memReq.valid)
				creditDue.push_back(cycleCount + int'($urandom_range(1, 6)));
			@(posedge clock);
			#1;
			cycleCount++;
			memCredit = 1'b0;
			idx = -1;
			for (int i = 0; i < creditDue.size(); i++) begin
				if (idx < 0 && creditDue[i] <= cycleCount)
					idx = i;
			end
			if (!blockCredits && idx >= 0) begin
				creditDue.delete(idx);
				memCredit = 1'b1;
			end
		end
	end

	initial begin
		#((NumOps + 100) * ClkPeriod);
		$display("Watchdog expired before all ops were presented");
		$display("Test FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		ex1Pkg::uop_t op;
		void'($urandom(56418));
		rstN = 1'b0;
		uop = '0;
		srIn = '0;
		lrIn = '0;
		dlrIn = '0;
		braFlush = 1'b0;
		repeat (2) @(posedge clock);
		#1;
		rstN = 1'b1;
		for (int n = 0; n < NumOps; n++) begin
			// back-pressure burst, credits withheld until the stall shows
			if (n == NumOps / 2) begin
				blockCredits = 1'b1;
				repeat (Credits + 2) begin
					op = randomOp();
					op.valid = 1'b1;
					op.cond = ex1Pkg::CcAlways;
					op.cmd = ex1Pkg::MovRm;
					presentOp(op, 1'b0);
				end
			end
			presentOp(randomOp(), ($urandom_range(0, 7) == 0));
		end
		// idle tail so the last op gets compared
		presentOp('0, 1'b0);
		repeat (2) @(negedge clock);
		if (acceptCount == 0 || !sawStall) begin
			$display("Run ended without accepted ops or without a credit stall");
			$display("Test FAILED");
			$fatal(1, "incomplete run");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: ex1Stage.f
+incdir+verif
verilog/ex1Pkg.sv
verilog/opDispatch.sv
verilog/addrGen.sv
verilog/srUpdate.sv
verilog/memIssue.sv
verilog/ex1Writeback.sv
verilog/ex1Stage.sv
verif/ex1StageTb.sv

// File: Makefile
TOP := ex1StageTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f ex1Stage.f -Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
